// ==== Bender.yml ====
package:
  name: fetch_frontend

sources:
  - logic/fetch_pkg.sv
  - logic/fetch_capture.sv
  - logic/branch_scan.sv
  - logic/predict_select.sv
  - logic/pc_gen.sv
  - logic/fetch_queue.sv
  - logic/fetch_frontend.sv
  - target: test
    files:
      - bench/fetch_checker.sv
      - bench/tb_fetch_frontend.sv

// ==== bench/fetch_checker.sv ====
/* decoder-side monitor of the fetch frontend. expected entries are pushed by
   the testbench before each test; entries are compared in order of transfer */
`timescale 1ns/1ps
`default_nettype none

module fetch_checker import fetch_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         req_i,
    input  logic         kill_i,
    input  fetch_entry_t entry_i,
    input  logic         valid_i,
    input  logic         ready_i,
    output int           remaining_o,
    output int           errors_o
);

    fetch_entry_t exp_q [$];
    int           test_errors;
    int           tests_run;
    int           tests_failed;
    // set while in reset, cleared after the first cycle out of it
    logic         out_of_reset_q;

    initial begin
        remaining_o    = 0;
        errors_o       = 0;
        test_errors    = 0;
        tests_run      = 0;
        tests_failed   = 0;
        out_of_reset_q = 1'b0;
    end

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic push_expected(input fetch_entry_t e);
        exp_q.push_back(e);
        remaining_o = exp_q.size();
    endtask

    // --------------------
    // per-test result
    // --------------------
    task automatic close_test(input int id);
        tests_run++;
        if (test_errors != 0) tests_failed++;
        errors_o = errors_o + test_errors;
        $display("test %0d: %0d errors", id, test_errors);
        test_errors = 0;
    endtask

    task automatic print_summary();
        $display("tests %0d, failing %0d, errors %0d", tests_run, tests_failed, errors_o);
    endtask

    // values are sampled before the edge updates the DUT
    always @(posedge clk_i) begin : watch
        fetch_entry_t exp;
        if (!rst_ni) begin
            compare_field("fetch_entry_valid_o", 32'(valid_i), 32'h0);
            out_of_reset_q <= 1'b1;
        end else begin
            if (out_of_reset_q) begin
                // boot address loads, nothing may leave yet
                compare_field("req_o", 32'(req_i), 32'h0);
                compare_field("kill_o", 32'(kill_i), 32'h0);
                compare_field("fetch_entry_valid_o", 32'(valid_i), 32'h0);
                out_of_reset_q <= 1'b0;
            end
            if (valid_i && ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("entry at pc %h arrived after the expected stream ended",
                             entry_i.pc);
                    test_errors++;
                end else begin
                    exp = exp_q.pop_front();
                    compare_field("fetch_entry_o.pc", entry_i.pc, exp.pc);
                    compare_field("fetch_entry_o.instr", entry_i.instr, exp.instr);
                    compare_field("fetch_entry_o.taken", 32'(entry_i.taken), 32'(exp.taken));
                    compare_field("fetch_entry_o.target", entry_i.target, exp.target);
                end
                remaining_o = exp_q.size();
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/fetch_stim.txt ====
// words 00-3f: instruction image at byte address 4*index, control flow only
// tests at 40: {nexp, kind, 0, boot} {target, trigger pc} then {taken, target, pc}
@08 0240006F
@12 0100006F
@18 00000863
@1B FE001CE3
@2F FC5FF06F
@40
06000004 00000000 00000004 00000008 0000000C 00000010 00000014 00000018
05000020 00000000 10440020 00000044 10580048 00000058 0000005C
08000060 00000000 00000060 00000064 00000068 1064006C 00000064 00000068
1064006C 00000064
14000080 00000000 00000080 00000084 00000088 0000008C 00000090 00000094
00000098 0000009C 000000A0 000000A4 000000A8 000000AC 000000B0 000000B4
000000B8 108000BC 00000080 00000084 00000088 0000008C
051000C0 001000C4 000000C0 000000C4 00000010 00000014 00000018
06200008 00800010 00000008 0000000C 00000010 00000080 00000084 00000088
00000000

// ==== bench/tb_fetch_frontend.sv ====
/* testbench of the fetch frontend. cache answers one cycle after each
   accepted request from a 64-word image; run is bounded by a cycle limit */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_frontend import fetch_pkg::*; ();

    localparam int unsigned NrSlots    = 2;
    localparam int unsigned QueueDepth = 8;
    localparam int unsigned MemWords   = 64;
    localparam int unsigned TableBase  = 'h40;
    localparam vaddr_t      EpcAddr    = 32'h0000_00e0;
    localparam vaddr_t      BlockMask  = vaddr_t'(NrSlots * INSTR_BYTES - 1);

    logic                 clk_i;
    logic                 rst_ni;
    logic                 req_o;
    vaddr_t               vaddr_o;
    logic                 ready_i;
    logic                 rsp_valid_i;
    vaddr_t               rsp_vaddr_i;
    instr_t [NrSlots-1:0] rsp_data_i;
    logic                 kill_o;
    fetch_entry_t         fetch_entry_o;
    logic                 fetch_entry_valid_o;
    logic                 fetch_entry_ready_i;
    vaddr_t               boot_addr_i;
    redirect_t            mispredict_i;
    logic                 eret_i;
    vaddr_t               epc_i;
    logic                 ex_valid_i;
    vaddr_t               trap_base_i;

    logic [31:0] stim [0:255];
    logic [15:0] lfsr;
    int          cycles;
    int          limit;
    int          remaining;
    int          errors;
    // request accepted and decoder transfer seen at the last edge
    logic        pend_q;
    vaddr_t      pend_addr_q;
    logic        popped_q;
    vaddr_t      popped_pc_q;

    fetch_frontend #(.NrSlots(NrSlots), .QueueDepth(QueueDepth)) u_dut (.*);

    fetch_checker u_check (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_i       (req_o),
        .kill_i      (kill_o),
        .entry_i     (fetch_entry_o),
        .valid_i     (fetch_entry_valid_o),
        .ready_i     (fetch_entry_ready_i),
        .remaining_o (remaining),
        .errors_o    (errors)
    );

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    // galois lfsr, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic instr_t fetch_word(input vaddr_t addr);
        return stim[(addr >> 2) % MemWords];
    endfunction

    // --------------------
    // cache model
    // --------------------
    always @(posedge clk_i) begin
        pend_q      <= req_o && ready_i && rst_ni;
        pend_addr_q <= vaddr_o & ~BlockMask;
        popped_q    <= fetch_entry_valid_o && fetch_entry_ready_i;
        popped_pc_q <= fetch_entry_o.pc;
        cycles      <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout after %0d cycles, stream not complete", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    // a response under kill_o is discarded by the frontend itself
    always @(negedge clk_i) begin
        rsp_valid_i = pend_q;
        rsp_vaddr_i = pend_addr_q;
        for (int i = 0; i < NrSlots; i++) begin
            rsp_data_i[i] = fetch_word(pend_addr_q + vaddr_t'(i * INSTR_BYTES));
        end
    end

    // header word, redirect word, then one word per expected entry
    task automatic run_test(input int id, input int base);
        logic [31:0]  hdr;
        logic [31:0]  redir;
        logic [31:0]  w;
        int           nexp;
        int           kind;
        logic         armed;
        fetch_entry_t exp;
        hdr   = stim[base];
        redir = stim[base+1];
        nexp  = hdr[31:24];
        kind  = hdr[23:20];
        armed = (kind != 0);
        for (int i = 0; i < nexp; i++) begin
            w          = stim[base+2+i];
            exp.pc     = vaddr_t'(w[15:0]);
            exp.instr  = fetch_word(exp.pc);
            exp.taken  = w[28];
            exp.target = vaddr_t'(w[27:16]);
            u_check.push_expected(exp);
        end
        @(negedge clk_i);
        rst_ni      = 1'b0;
        boot_addr_i = vaddr_t'(hdr[15:0]);
        repeat (8) @(negedge clk_i);
        rst_ni = 1'b1;
        while (remaining != 0) begin
            @(negedge clk_i);
            mispredict_i = '0;
            eret_i       = 1'b0;
            ex_valid_i   = 1'b0;
            lfsr         = lfsr_next(lfsr);
            fetch_entry_ready_i = lfsr[0] && (remaining != 0);
            if (armed && popped_q && popped_pc_q == vaddr_t'(redir[15:0])) begin
                armed = 1'b0;
                // decoder stalls while the queue flushes
                fetch_entry_ready_i = 1'b0;
                if (kind == 1) begin
                    mispredict_i = '{valid: 1'b1, target: vaddr_t'(redir[31:16])};
                end else begin
                    eret_i      = 1'b1;
                    ex_valid_i  = 1'b1;
                    trap_base_i = vaddr_t'(redir[31:16]);
                end
            end
        end
        fetch_entry_ready_i = 1'b0;
        u_check.close_test(id);
    endtask

    initial begin : main
        int base;
        int total;
        int id;
        // each test asserts reset on its first falling edge
        rst_ni = 1'b1;
        ready_i = 1'b1;
        fetch_entry_ready_i = 1'b0;
        boot_addr_i = '0;
        mispredict_i = '0;
        eret_i = 1'b0;
        epc_i = EpcAddr;
        ex_valid_i = 1'b0;
        trap_base_i = '0;
        rsp_valid_i = 1'b0;
        rsp_vaddr_i = '0;
        rsp_data_i = '0;
        lfsr = 16'd10;
        cycles = 0;
        limit = 0;
        // image fill is addi x0 with the byte address as immediate
        for (int i = 0; i < 256; i++) begin
            stim[i] = (i < MemWords) ? {12'(i * 4), 20'h00013} : 32'h0;
        end
        $readmemh("bench/fetch_stim.txt", stim);
        total = 0;
        base  = TableBase;
        while (stim[base] != 32'h0) begin
            total += stim[base][31:24];
            base  += 2 + stim[base][31:24];
        end
        limit = total * 8 + 200;
        id    = 1;
        base  = TableBase;
        while (stim[base] != 32'h0) begin
            run_test(id, base);
            base += 2 + stim[base][31:24];
            id++;
        end
        u_check.print_summary();
        if (errors == 0 && id > 1) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/fetch_pkg.sv
logic/fetch_capture.sv
logic/branch_scan.sv
logic/predict_select.sv
logic/pc_gen.sv
logic/fetch_queue.sv
logic/fetch_frontend.sv
bench/fetch_checker.sv
bench/tb_fetch_frontend.sv

// ==== logic/branch_scan.sv ====
/* static decode of one RV32I word. only JAL, JALR and conditional
   branches are classified, everything else is CF_NONE */
`timescale 1ns/1ps
`default_nettype none

module branch_scan import fetch_pkg::*; (
    input  instr_t instr_i,
    output scan_t  scan_o
);

    logic [6:0] opcode;
    vaddr_t     imm_j;
    vaddr_t     imm_b;

    assign opcode = instr_i[6:0];

    // --------------------
    // immediates
    // --------------------
    // J-type, bit 0 is always zero
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};
    // B-type, sign sits in bit 31 like every other format
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};

    always_comb begin
        scan_o.kind   = CF_NONE;
        scan_o.offset = '0;
        case (opcode)
            OPC_JAL: begin
                scan_o.kind   = CF_JUMP;
                scan_o.offset = imm_j;
            end
            OPC_BRANCH: begin
                scan_o.kind   = CF_BRANCH;
                scan_o.offset = imm_b;
            end
            OPC_JALR: begin
                // target needs a register, never predicted
                scan_o.kind   = CF_JALR;
            end
            default: begin
                scan_o.kind   = CF_NONE;
                scan_o.offset = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/fetch_capture.sv ====
/* response register of the fetch path. expects the cache to answer exactly
   one cycle after the request; NrSlots is a power of two, at least 2 */
`timescale 1ns/1ps
`default_nettype none

module fetch_capture import fetch_pkg::*; #(
    parameter int unsigned NrSlots = 2
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      flush_i,
    input  logic                      rsp_valid_i,
    input  vaddr_t                    rsp_vaddr_i,
    input  instr_t [NrSlots-1:0]      rsp_data_i,
    input  vaddr_t                    start_vaddr_i,
    output instr_t [NrSlots-1:0]      slot_instr_o,
    output vaddr_t [NrSlots-1:0]      slot_addr_o,
    output logic   [NrSlots-1:0]      slot_live_o
);

    localparam int unsigned SlotBits = $clog2(NrSlots);
    localparam int unsigned ByteBits = $clog2(INSTR_BYTES);

    logic                      valid_q;
    vaddr_t                    block_q;
    instr_t [NrSlots-1:0]      data_q;
    logic   [SlotBits-1:0]     first_q;
    // slot of the address requested last cycle
    logic   [SlotBits-1:0]     pend_slot_q;

    // valid flag is the only control state here
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= rsp_valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        // the response belongs to the request of the previous cycle
        pend_slot_q <= start_vaddr_i[SlotBits+ByteBits-1:ByteBits];
        if (rsp_valid_i) begin
            block_q <= rsp_vaddr_i;
            data_q  <= rsp_data_i;
            first_q <= pend_slot_q;
        end
    end

    // --------------------
    // per-slot split
    // --------------------
    always_comb begin
        for (int i = 0; i < NrSlots; i++) begin
            slot_instr_o[i] = data_q[i];
            slot_addr_o[i]  = block_q + vaddr_t'(i * INSTR_BYTES);
            // slots below the entry point of a jump are dead
            slot_live_o[i]  = valid_q && (SlotBits'(i) >= first_q);
        end
    end

endmodule

`default_nettype wire

// ==== logic/fetch_frontend.sv ====
/* RV32I fetch frontend. the cache answers one cycle after an accepted request;
   kill_o drops the response returned in that same cycle, a request accepted
   while kill_o is high stays valid. NrSlots >= 2 and QueueDepth powers of two */
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend import fetch_pkg::*; #(
    parameter int unsigned NrSlots    = 2,
    parameter int unsigned QueueDepth = 8
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    // cache request
    output logic                 req_o,
    output vaddr_t               vaddr_o,
    input  logic                 ready_i,
    // cache response
    input  logic                 rsp_valid_i,
    input  vaddr_t               rsp_vaddr_i,
    input  instr_t [NrSlots-1:0] rsp_data_i,
    output logic                 kill_o,
    // decoder
    output fetch_entry_t         fetch_entry_o,
    output logic                 fetch_entry_valid_o,
    input  logic                 fetch_entry_ready_i,
    // redirects
    input  vaddr_t               boot_addr_i,
    input  redirect_t            mispredict_i,
    input  logic                 eret_i,
    input  vaddr_t               epc_i,
    input  logic                 ex_valid_i,
    input  vaddr_t               trap_base_i
);

    instr_t       [NrSlots-1:0] slot_instr;
    vaddr_t       [NrSlots-1:0] slot_addr;
    logic         [NrSlots-1:0] slot_live;
    scan_t        [NrSlots-1:0] scan;
    fetch_entry_t [NrSlots-1:0] entries;
    logic         [NrSlots-1:0] wr_en;
    logic                       bp_valid;
    vaddr_t                     bp_target;
    logic                       has_room;
    logic                       req_fire;
    logic                       flush;

    // request only while the queue can take what comes back
    assign req_o    = has_room;
    assign req_fire = has_room & ready_i;

    // capture is cleared on any kill, the wrong-path block is dropped
    fetch_capture #(.NrSlots(NrSlots)) i_capture (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (kill_o),
        .rsp_valid_i   (rsp_valid_i),
        .rsp_vaddr_i   (rsp_vaddr_i),
        .rsp_data_i    (rsp_data_i),
        .start_vaddr_i (vaddr_o),
        .slot_instr_o  (slot_instr),
        .slot_addr_o   (slot_addr),
        .slot_live_o   (slot_live)
    );

    // --------------------
    // one scanner per slot
    // --------------------
    for (genvar i = 0; i < NrSlots; i++) begin : gen_scan
        branch_scan i_scan (
            .instr_i (slot_instr[i]),
            .scan_o  (scan[i])
        );
    end

    predict_select #(.NrSlots(NrSlots)) i_predict (
        .slot_instr_i (slot_instr),
        .slot_addr_i  (slot_addr),
        .slot_live_i  (slot_live),
        .scan_i       (scan),
        .entries_o    (entries),
        .wr_en_o      (wr_en),
        .bp_valid_o   (bp_valid),
        .bp_target_o  (bp_target)
    );

    pc_gen #(.NrSlots(NrSlots)) i_pc_gen (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .boot_addr_i  (boot_addr_i),
        .bp_valid_i   (bp_valid),
        .bp_target_i  (bp_target),
        .mispredict_i (mispredict_i),
        .eret_i       (eret_i),
        .epc_i        (epc_i),
        .ex_valid_i   (ex_valid_i),
        .trap_base_i  (trap_base_i),
        .req_fire_i   (req_fire),
        .vaddr_o      (vaddr_o),
        .flush_o      (flush),
        .kill_o       (kill_o)
    );

    fetch_queue #(
        .NrSlots    (NrSlots),
        .QueueDepth (QueueDepth)
    ) i_queue (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush),
        .entries_i           (entries),
        .wr_en_i             (wr_en),
        .has_room_o          (has_room),
        .fetch_entry_o       (fetch_entry_o),
        .fetch_entry_valid_o (fetch_entry_valid_o),
        .fetch_entry_ready_i (fetch_entry_ready_i)
    );

endmodule

`default_nettype wire

// ==== logic/fetch_pkg.sv ====
/* shared types for the RV32I fetch frontend. uncompressed code only,
   every slot is one aligned 32-bit word */
`default_nettype none

package fetch_pkg;

    // --------------------
    // widths
    // --------------------
    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] instr_t;

    // byte step between two slots of a block
    localparam int unsigned INSTR_BYTES = 4;

    // major opcodes the scanner looks for
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // control-flow class of one slot
    typedef enum logic [1:0] {
        CF_NONE,
        CF_BRANCH,
        CF_JUMP,
        CF_JALR
    } cf_kind_e;

    // scanner result, offset already sign extended
    typedef struct packed {
        cf_kind_e kind;
        vaddr_t   offset;
    } scan_t;

    // one instruction toward the decoder
    typedef struct packed {
        vaddr_t pc;
        instr_t instr;
        logic   taken;   // frontend redirected after this one
        vaddr_t target;  // zero when not taken
    } fetch_entry_t;

    // back-end redirect
    typedef struct packed {
        logic   valid;
        vaddr_t target;
    } redirect_t;

endpackage

`default_nettype wire

// ==== logic/fetch_queue.sv ====
/* instruction FIFO toward the decoder. QueueDepth must be a power of two
   and at least 2*NrSlots; room is reserved for two blocks in flight */
`timescale 1ns/1ps
`default_nettype none

module fetch_queue import fetch_pkg::*; #(
    parameter int unsigned NrSlots    = 2,
    parameter int unsigned QueueDepth = 8
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       flush_i,
    input  fetch_entry_t [NrSlots-1:0] entries_i,
    input  logic         [NrSlots-1:0] wr_en_i,
    output logic                       has_room_o,
    output fetch_entry_t               fetch_entry_o,
    output logic                       fetch_entry_valid_o,
    input  logic                       fetch_entry_ready_i
);

    localparam int unsigned PtrW = $clog2(QueueDepth);
    localparam int unsigned CntW = $clog2(QueueDepth + 1);

    fetch_entry_t    mem_q [QueueDepth];
    logic [PtrW-1:0] rd_ptr_q;
    logic [PtrW-1:0] wr_ptr_q;
    logic [CntW-1:0] count_q;
    logic [CntW-1:0] count_d;
    logic [CntW-1:0] n_wr;
    logic [PtrW-1:0] wr_idx [NrSlots];
    logic [CntW:0]   claim;
    logic            pop;
    // closed for one cycle after reset while the pc loads the boot address
    logic            open_q;

    // --------------------
    // write compaction
    // --------------------
    always_comb begin
        logic [PtrW-1:0] ofs;
        ofs  = '0;
        n_wr = '0;
        for (int i = 0; i < NrSlots; i++) begin
            // enabled slots land back to back in slot order
            wr_idx[i] = wr_ptr_q + ofs;
            if (wr_en_i[i]) begin
                ofs  = ofs + 1'b1;
                n_wr = n_wr + 1'b1;
            end
        end
    end

    assign fetch_entry_valid_o = (count_q != '0);
    assign fetch_entry_o       = mem_q[rd_ptr_q];
    assign pop                 = fetch_entry_valid_o & fetch_entry_ready_i;
    assign count_d             = count_q + n_wr - CntW'(pop);

    // current fill plus this cycle's write, then one block at the cache
    // and one new request must still fit
    assign claim      = {1'b0, count_q} + {1'b0, n_wr} + (CntW+1)'(2 * NrSlots);
    assign has_room_o = open_q & ~flush_i & (claim <= (CntW+1)'(QueueDepth));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            open_q   <= 1'b0;
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            open_q <= 1'b1;
            if (flush_i) begin
                rd_ptr_q <= '0;
                wr_ptr_q <= '0;
                count_q  <= '0;
            end else begin
                rd_ptr_q <= rd_ptr_q + PtrW'(pop);
                wr_ptr_q <= wr_ptr_q + PtrW'(n_wr);
                count_q  <= count_d;
            end
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < NrSlots; i++) begin
            if (wr_en_i[i] && !flush_i) begin
                mem_q[wr_idx[i]] <= entries_i[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/pc_gen.sv ====
/* next-pc selection. boot address is loaded in the first cycle out of
   reset; vaddr_o is the exact pc, the cache aligns it to the block */
`timescale 1ns/1ps
`default_nettype none

module pc_gen import fetch_pkg::*; #(
    parameter int unsigned NrSlots = 2
) (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  vaddr_t    boot_addr_i,
    input  logic      bp_valid_i,
    input  vaddr_t    bp_target_i,
    input  redirect_t mispredict_i,
    input  logic      eret_i,
    input  vaddr_t    epc_i,
    input  logic      ex_valid_i,
    input  vaddr_t    trap_base_i,
    input  logic      req_fire_i,
    output vaddr_t    vaddr_o,
    output logic      flush_o,
    output logic      kill_o
);

    localparam vaddr_t BlockStep = vaddr_t'(NrSlots * INSTR_BYTES);
    localparam vaddr_t BlockMask = vaddr_t'(NrSlots * INSTR_BYTES - 1);

    logic   npc_load_q;
    vaddr_t npc_q;
    vaddr_t npc_d;
    vaddr_t fetch_addr;

    // --------------------
    // redirect priority
    // --------------------
    always_comb begin
        // hold by default, boot address while loading
        fetch_addr = npc_load_q ? boot_addr_i : npc_q;
        npc_d      = fetch_addr;
        // prediction also steers the request of this cycle
        if (bp_valid_i) begin
            fetch_addr = bp_target_i;
            npc_d      = bp_target_i;
        end
        // sequential step from the block base
        if (req_fire_i) npc_d = (fetch_addr & ~BlockMask) + BlockStep;
        if (mispredict_i.valid) npc_d = mispredict_i.target;
        if (eret_i) npc_d = epc_i;
        // exception beats everything
        if (ex_valid_i) npc_d = trap_base_i;
    end

    assign vaddr_o = fetch_addr;
    // back-end redirects flush capture and queue
    assign flush_o = mispredict_i.valid | eret_i | ex_valid_i;
    // a prediction only drops what is still at the cache
    assign kill_o  = flush_o | bp_valid_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            npc_load_q <= 1'b1;
            npc_q      <= '0;
        end else begin
            npc_load_q <= 1'b0;
            npc_q      <= npc_d;
        end
    end

endmodule

`default_nettype wire

// ==== logic/predict_select.sv ====
/* static prediction over one block. jal taken, backward branch taken,
   jalr never; the lowest taken live slot ends the block */
`timescale 1ns/1ps
`default_nettype none

module predict_select import fetch_pkg::*; #(
    parameter int unsigned NrSlots = 2
) (
    input  instr_t       [NrSlots-1:0] slot_instr_i,
    input  vaddr_t       [NrSlots-1:0] slot_addr_i,
    input  logic         [NrSlots-1:0] slot_live_i,
    input  scan_t        [NrSlots-1:0] scan_i,
    output fetch_entry_t [NrSlots-1:0] entries_o,
    output logic         [NrSlots-1:0] wr_en_o,
    output logic                       bp_valid_o,
    output vaddr_t                     bp_target_o
);

    logic   [NrSlots-1:0] pred_taken;
    vaddr_t [NrSlots-1:0] pred_target;

    // --------------------
    // per-slot guess
    // --------------------
    always_comb begin
        for (int i = 0; i < NrSlots; i++) begin
            // sign of the offset decides for branches
            pred_taken[i]  = (scan_i[i].kind == CF_JUMP)
                          || ((scan_i[i].kind == CF_BRANCH) && scan_i[i].offset[31]);
            pred_target[i] = slot_addr_i[i] + scan_i[i].offset;
        end
    end

    // --------------------
    // lowest taken wins
    // --------------------
    always_comb begin
        logic blocked;
        logic hit;
        blocked     = 1'b0;
        bp_valid_o  = 1'b0;
        bp_target_o = '0;
        for (int i = 0; i < NrSlots; i++) begin
            hit = slot_live_i[i] && !blocked && pred_taken[i];
            // slots after a taken one are on the wrong path
            wr_en_o[i]          = slot_live_i[i] && !blocked;
            entries_o[i].pc     = slot_addr_i[i];
            entries_o[i].instr  = slot_instr_i[i];
            entries_o[i].taken  = hit;
            entries_o[i].target = hit ? pred_target[i] : '0;
            if (hit) begin
                bp_valid_o  = 1'b1;
                bp_target_o = pred_target[i];
                blocked     = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire
